// ==== logic/wideword_pkg.sv ====
// shared widths, register map and encodings; bit 0 is the MSB of every wide word, map needs >= 8 address bits
package wideword_pkg;

	// ======================================================================
	// widths
	// ======================================================================
	localparam int WORD_BITS     = 128;            // operand and result width
	localparam int BYTES         = WORD_BITS / 8;  // 16 bytes per word
	localparam int AXI_DATA_BITS = 32;             // AXI4-Lite data bus
	localparam int AXI_ADDR_BITS = 8;              // byte address of the map

	typedef logic [0:WORD_BITS-1] wide_word_t;     // big-endian numbering, [0] is MSB

	// ======================================================================
	// encodings
	// ======================================================================
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,  // lane add, no carry across lanes
		OP_AND = 3'd1,
		OP_NOT = 3'd2,  // inverts A, B unused
		OP_OR  = 3'd3,
		OP_XOR = 3'd4,
		OP_SUB = 3'd5,  // lane subtract, no borrow across lanes
		OP_PRM = 3'd6   // byte permute; 7 is reserved and yields zero
	} alu_op_e;

	typedef enum logic [1:0] {
		W8  = 2'd0,
		W16 = 2'd1,
		W32 = 2'd2      // 3 reserved, lane ops give zero
	} lane_width_e;

	// register map, byte addresses
	localparam logic [AXI_ADDR_BITS-1:0] ADDR_A0     = 8'h00;  // A words 0..3, word 0 most significant
	localparam logic [AXI_ADDR_BITS-1:0] ADDR_B0     = 8'h10;  // B words 0..3
	localparam logic [AXI_ADDR_BITS-1:0] ADDR_CTRL   = 8'h20;  // op [2:0], width [5:4]
	localparam logic [AXI_ADDR_BITS-1:0] ADDR_STATUS = 8'h24;  // done in bit 0
	localparam logic [AXI_ADDR_BITS-1:0] ADDR_RES0   = 8'h30;  // result words, read only

	// response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// ==== logic/alu_req_if.sv ====
// one ALU request and its result; start is a single-cycle pulse, done follows it by one cycle
`timescale 1ns/1ps

interface alu_req_if;
	import wideword_pkg::*;

	wide_word_t  a;       // operand A at the start edge
	wide_word_t  b;       // operand B, also the permute selector
	alu_op_e     op;      // valid while start is high
	lane_width_e width;   // lane width for lane ops
	logic        start;   // request strobe
	wide_word_t  result;  // registered result
	logic        done;    // one-cycle completion strobe

	// register block side
	modport regs (
		output a,
		output b,
		output op,
		output width,
		output start,
		input  result,
		input  done
	);

	// ALU core side
	modport core (
		input  a,
		input  b,
		input  op,
		input  width,
		input  start,
		output result,
		output done
	);

endinterface

// ==== logic/lane_alu.sv ====
// combinational lane ALU for 8/16/32-bit lanes; reserved width or non-lane opcode gives zero
`timescale 1ns/1ps

module lane_alu (
	input  wideword_pkg::wide_word_t  a,
	input  wideword_pkg::wide_word_t  b,
	input  wideword_pkg::alu_op_e     op,
	input  wideword_pkg::lane_width_e width,
	output wideword_pkg::wide_word_t  result
);
	import wideword_pkg::*;

	// one lane at up to 32 bits; narrower lanes are zero-extended and truncated after
	function automatic logic [31:0] lane_fn(input alu_op_e code, input logic [31:0] x,
		input logic [31:0] y);
		case (code)
			OP_ADD:  return x + y;
			OP_SUB:  return x - y;   // wraps inside the lane
			OP_AND:  return x & y;
			OP_OR:   return x | y;
			OP_XOR:  return x ^ y;
			OP_NOT:  return ~x;      // B ignored
			default: return '0;      // PRM and reserved are not lane ops
		endcase
	endfunction

	always_comb
	begin : lane_mux
		logic [31:0] t;             // lane result before truncation
		t = '0;
		result = '0;                // reserved width falls through as zero
		case (width)
			W8:
			begin
				for (int i = 0; i < WORD_BITS / 8; i++)
				begin
					t = lane_fn(op, 32'(a[i*8 +: 8]), 32'(b[i*8 +: 8]));
					result[i*8 +: 8] = t[7:0];      // lane 0 is the top byte
				end
			end
			W16:
			begin
				for (int i = 0; i < WORD_BITS / 16; i++)
				begin
					t = lane_fn(op, 32'(a[i*16 +: 16]), 32'(b[i*16 +: 16]));
					result[i*16 +: 16] = t[15:0];
				end
			end
			W32:
			begin
				for (int i = 0; i < WORD_BITS / 32; i++)
				begin
					t = lane_fn(op, a[i*32 +: 32], b[i*32 +: 32]);
					result[i*32 +: 32] = t;
				end
			end
			default:
			begin
				result = '0;
			end
		endcase
	end

endmodule

// ==== logic/byte_permute.sv ====
// PRM byte permute: out byte i = A byte (low nibble of sel byte i), byte 0 is the most significant
`timescale 1ns/1ps

module byte_permute (
	input  wideword_pkg::wide_word_t a,
	input  wideword_pkg::wide_word_t sel,
	output wideword_pkg::wide_word_t result
);
	import wideword_pkg::*;

	logic [7:0] a_bytes [0:BYTES-1];  // A split into bytes, index 0 = top byte

	genvar i;
	generate
		for (i = 0; i < BYTES; i++)
		begin : g_byte
			logic [3:0] idx;             // selector nibble for this output byte

			assign a_bytes[i] = a[i*8 +: 8];
			// low nibble sits in the less significant half, higher bit numbers
			assign idx = sel[i*8+4 +: 4];  // high nibble ignored
			assign result[i*8 +: 8] = a_bytes[idx];  // 16-way selector
		end
	endgenerate

endmodule

// ==== logic/alu_core.sv ====
// ALU core with one result register; result and done appear one cycle after start, no stall
`timescale 1ns/1ps

module alu_core (
	input logic     clk,
	input logic     rst,
	alu_req_if.core req
);
	import wideword_pkg::*;

	wide_word_t lane_res;  // lane ALU output
	wide_word_t prm_res;   // permute output
	wide_word_t next_res;  // value captured on start

	// ======================================================================
	// datapath
	// ======================================================================
	lane_alu u_lane (
		.a      (req.a),
		.b      (req.b),
		.op     (req.op),
		.width  (req.width),
		.result (lane_res)
	);

	byte_permute u_prm (
		.a      (req.a),
		.sel    (req.b),    // B carries the selectors
		.result (prm_res)
	);

	always_comb
	begin
		case (req.op)
			OP_PRM:
			begin
				next_res = prm_res;
			end
			OP_ADD, OP_AND, OP_NOT, OP_OR, OP_XOR, OP_SUB:
			begin
				next_res = lane_res;  // already zero for reserved width
			end
			default:
			begin
				next_res = '0;        // opcode 7
			end
		endcase
	end

	// ======================================================================
	// result stage
	// ======================================================================
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			req.result <= '0;
			req.done   <= 1'b0;
		end
		else
		begin
			req.done <= req.start;  // exactly one cycle per start
			if (req.start)
			begin
				req.result <= next_res;  // back-to-back starts each land here
			end
		end
	end

endmodule

// ==== logic/axil_regs.sv ====
// AXI4-Lite register block, one write and one read in flight; needs ADDR_BITS >= 8, upper bits must be 0
`timescale 1ns/1ps

module axil_regs #(
	parameter int ADDR_BITS = wideword_pkg::AXI_ADDR_BITS
) (
	input  logic                                     clk,
	input  logic                                     rst,
	input  logic [ADDR_BITS-1:0]                     awaddr,
	input  logic                                     awvalid,
	output logic                                     awready,
	input  logic [wideword_pkg::AXI_DATA_BITS-1:0]   wdata,
	input  logic [wideword_pkg::AXI_DATA_BITS/8-1:0] wstrb,
	input  logic                                     wvalid,
	output logic                                     wready,
	output logic [1:0]                               bresp,
	output logic                                     bvalid,
	input  logic                                     bready,
	input  logic [ADDR_BITS-1:0]                     araddr,
	input  logic                                     arvalid,
	output logic                                     arready,
	output logic [wideword_pkg::AXI_DATA_BITS-1:0]   rdata,
	output logic [1:0]                               rresp,
	output logic                                     rvalid,
	input  logic                                     rready,
	alu_req_if.regs                                  req
);
	import wideword_pkg::*;

	localparam int WORDS = WORD_BITS / AXI_DATA_BITS;  // 4 bus words per wide word
	localparam int STRB  = AXI_DATA_BITS / 8;

	logic [AXI_DATA_BITS-1:0] a_q   [0:WORDS-1];  // word 0 = bits 0..31
	logic [AXI_DATA_BITS-1:0] b_q   [0:WORDS-1];
	logic [AXI_DATA_BITS-1:0] res_q [0:WORDS-1];  // copy of the core result
	alu_op_e                  op_q;
	lane_width_e              width_q;
	logic                     done_q;             // sticky status flag
	logic                     wr_ready_q;         // drives awready and wready together
	logic                     rd_ready_q;
	logic                     wr_hs, wr_a, wr_b, wr_ctrl, wr_ro, start;
	logic                     rd_ok;
	logic [AXI_DATA_BITS-1:0] rd_val;
	logic                     ar_hs;

	// 16-byte block of four aligned words
	function automatic logic hit_block(input logic [ADDR_BITS-1:0] addr,
		input logic [AXI_ADDR_BITS-1:0] base);
		return ({addr[ADDR_BITS-1:4], 4'h0} == ADDR_BITS'(base)) && (addr[1:0] == 2'b00);
	endfunction

	function automatic logic hit_word(input logic [ADDR_BITS-1:0] addr,
		input logic [AXI_ADDR_BITS-1:0] base);
		return addr == ADDR_BITS'(base);
	endfunction

	// ======================================================================
	// write channel
	// ======================================================================
	assign awready = wr_ready_q;
	assign wready  = wr_ready_q;
	assign wr_hs   = awvalid & wvalid & wr_ready_q;
	assign wr_a    = hit_block(awaddr, ADDR_A0);
	assign wr_b    = hit_block(awaddr, ADDR_B0);
	assign wr_ctrl = hit_word(awaddr, ADDR_CTRL);
	assign wr_ro   = hit_word(awaddr, ADDR_STATUS) | hit_block(awaddr, ADDR_RES0);  // OKAY, dropped
	assign start   = wr_hs & wr_ctrl & (&wstrb);  // partial control write is ignored

	// request side, op and width come straight off the bus in the start cycle
	assign req.start = start;
	assign req.op    = start ? alu_op_e'(wdata[2:0]) : op_q;
	assign req.width = start ? lane_width_e'(wdata[5:4]) : width_q;
	assign req.a     = {a_q[0], a_q[1], a_q[2], a_q[3]};
	assign req.b     = {b_q[0], b_q[1], b_q[2], b_q[3]};

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ready_q <= 1'b0;
			bvalid     <= 1'b0;
			bresp      <= RESP_OKAY;
		end
		else
		begin
			wr_ready_q <= awvalid & wvalid & ~wr_ready_q & ~bvalid;  // one-cycle pulse
			if (wr_hs)
			begin
				bvalid <= 1'b1;
				bresp  <= (wr_a | wr_b | wr_ctrl | wr_ro) ? RESP_OKAY : RESP_SLVERR;
			end
			else if (bvalid & bready)
			begin
				bvalid <= 1'b0;
			end
		end
	end

	// ======================================================================
	// register file
	// ======================================================================
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int w = 0; w < WORDS; w++)
			begin
				a_q[w]   <= '0;
				b_q[w]   <= '0;
				res_q[w] <= '0;
			end
			op_q    <= OP_ADD;
			width_q <= W8;
			done_q  <= 1'b0;
		end
		else
		begin
			for (int k = 0; k < STRB; k++)
			begin
				if (wr_hs & wr_a & wstrb[k])
				begin
					a_q[awaddr[3:2]][k*8 +: 8] <= wdata[k*8 +: 8];  // byte lanes honoured
				end
				if (wr_hs & wr_b & wstrb[k])
				begin
					b_q[awaddr[3:2]][k*8 +: 8] <= wdata[k*8 +: 8];
				end
			end
			if (start)
			begin
				op_q    <= alu_op_e'(wdata[2:0]);
				width_q <= lane_width_e'(wdata[5:4]);
				done_q  <= 1'b0;  // new op clears status
			end
			else if (req.done)
			begin
				done_q <= 1'b1;
			end
			if (req.done)
			begin
				for (int w = 0; w < WORDS; w++)
				begin
					res_q[w] <= req.result[w*AXI_DATA_BITS +: AXI_DATA_BITS];
				end
			end
		end
	end

	// ======================================================================
	// read channel
	// ======================================================================
	assign arready = rd_ready_q;
	assign ar_hs   = arvalid & rd_ready_q;

	always_comb
	begin
		rd_val = '0;
		rd_ok  = 1'b1;
		if (hit_block(araddr, ADDR_A0))
		begin
			rd_val = a_q[araddr[3:2]];
		end
		else if (hit_block(araddr, ADDR_B0))
		begin
			rd_val = b_q[araddr[3:2]];
		end
		else if (hit_word(araddr, ADDR_CTRL))
		begin
			rd_val[2:0] = op_q;
			rd_val[5:4] = width_q;
		end
		else if (hit_word(araddr, ADDR_STATUS))
		begin
			rd_val[0] = done_q;
		end
		else if (hit_block(araddr, ADDR_RES0))
		begin
			rd_val = res_q[araddr[3:2]];
		end
		else
		begin
			rd_ok = 1'b0;  // unmapped reads as zero
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_ready_q <= 1'b0;
			rvalid     <= 1'b0;
			rdata      <= '0;
			rresp      <= RESP_OKAY;
		end
		else if (ar_hs)
		begin
			rd_ready_q <= 1'b0;    // held low until rready
			rvalid     <= 1'b1;
			rdata      <= rd_val;
			rresp      <= rd_ok ? RESP_OKAY : RESP_SLVERR;
		end
		else if (rvalid & rready)
		begin
			rd_ready_q <= 1'b1;
			rvalid     <= 1'b0;
		end
		else if (!rvalid)
		begin
			rd_ready_q <= 1'b1;    // first cycle out of reset
		end
	end

endmodule

// ==== logic/wideword_alu_top.sv ====
// wide-word SIMD ALU behind an AXI4-Lite slave; single clock, synchronous active-high reset
`timescale 1ns/1ps

module wideword_alu_top #(
	parameter int ADDR_BITS = wideword_pkg::AXI_ADDR_BITS
) (
	input  logic                                     clk,
	input  logic                                     rst,
	input  logic [ADDR_BITS-1:0]                     awaddr,
	input  logic                                     awvalid,
	output logic                                     awready,
	input  logic [wideword_pkg::AXI_DATA_BITS-1:0]   wdata,
	input  logic [wideword_pkg::AXI_DATA_BITS/8-1:0] wstrb,
	input  logic                                     wvalid,
	output logic                                     wready,
	output logic [1:0]                               bresp,
	output logic                                     bvalid,
	input  logic                                     bready,
	input  logic [ADDR_BITS-1:0]                     araddr,
	input  logic                                     arvalid,
	output logic                                     arready,
	output logic [wideword_pkg::AXI_DATA_BITS-1:0]   rdata,
	output logic [1:0]                               rresp,
	output logic                                     rvalid,
	input  logic                                     rready
);

	alu_req_if u_req ();  // register block to core

	axil_regs #(
		.ADDR_BITS (ADDR_BITS)
	) u_regs (
		.clk     (clk),
		.rst     (rst),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.req     (u_req)
	);

	alu_core u_core (
		.clk (clk),
		.rst (rst),
		.req (u_req)
	);

endmodule

// ==== verif/wideword_assertions.sv ====
// AXI4-Lite hold rules and start/done timing for axil_regs; checks are off while rst is high
`timescale 1ns/1ps

module wideword_assertions (
	input logic                                   clk,
	input logic                                   rst,
	input logic                                   bvalid,
	input logic                                   bready,
	input logic                                   rvalid,
	input logic                                   rready,
	input logic [wideword_pkg::AXI_DATA_BITS-1:0] rdata,
	input logic [1:0]                             rresp,
	input logic                                   start,
	input logic                                   done
);

	b_hold: assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	r_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else $error("read data changed or dropped before rready");

	// one done per start, exactly one cycle later
	done_timing: assert property (@(posedge clk) disable iff (rst) done == $past(start))
		else $error("done does not follow start by one cycle");

	reset_quiet: assert property (@(posedge clk) rst |=> !bvalid && !rvalid)
		else $error("response valid high during reset");

endmodule

bind axil_regs wideword_assertions u_assert (
	.clk    (clk),
	.rst    (rst),
	.bvalid (bvalid),
	.bready (bready),
	.rvalid (rvalid),
	.rready (rready),
	.rdata  (rdata),
	.rresp  (rresp),
	.start  (start),
	.done   (req.done)
);

// ==== verif/tb_wideword_alu.sv ====
// self-checking testbench; LFSR-random AXI4-Lite traffic with fixed seed, model follows the lane/permute rules
`timescale 1ns/1ps

module tb_wideword_alu;
	import wideword_pkg::*;

	localparam int TIMEOUT = 100;  // cycles allowed per handshake wait

	logic        clk = 1'b0;
	logic        rst;
	logic [7:0]  awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [7:0]  araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;

	logic [31:0]  lfsr = 32'd96673;  // Galois state
	int           delay_bits = 1;    // ready delay 0 .. 2**n-1 cycles
	int           errors = 0;
	int           tests = 0;
	int           failed = 0;
	logic [127:0] last_exp = '0;     // model result of the newest op

	wideword_alu_top #(.ADDR_BITS(AXI_ADDR_BITS)) u_dut (.*);

	always #2 clk = ~clk;  // 4 ns period

	// ======================================================================
	// random numbers and model
	// ======================================================================
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);  // one step per bit
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [127:0] rand_word();
		logic [127:0] v;
		v = '0;
		for (int k = 0; k < 4; k++)
			v = {v[95:0], rand_bits(32)};
		return v;
	endfunction

	// expected result; byte/lane 0 is the top of the word
	function automatic logic [127:0] model(input logic [127:0] a, input logic [127:0] b,
		input logic [2:0] op, input logic [1:0] w);
		logic [127:0] r;
		logic [127:0] m;
		logic [31:0]  x;
		logic [31:0]  y;
		logic [31:0]  z;
		int           lw;
		int           s;
		r = '0;
		lw = (w == 2'd0) ? 8 : (w == 2'd1) ? 16 : 32;
		m = (128'd1 << lw) - 128'd1;
		if (op == OP_PRM)
		begin
			for (int i = 0; i < 16; i++)
			begin
				s = int'(b[120-8*i +: 4]);          // low nibble of selector byte i
				r[127-8*i -: 8] = a[127-8*s -: 8];
			end
		end
		else if (op != 3'd7 && w != 2'd3)
		begin
			for (int i = 0; i < 128 / lw; i++)
			begin
				x = 32'(a >> (i * lw));             // lane in the low bits, rest masked off
				y = 32'(b >> (i * lw));
				case (op)
					OP_ADD:  z = x + y;
					OP_SUB:  z = x - y;
					OP_AND:  z = x & y;
					OP_OR:   z = x | y;
					OP_XOR:  z = x ^ y;
					OP_NOT:  z = ~x;
					default: z = '0;
				endcase
				r = r | ((128'(z) & m) << (i * lw));  // no carry leaks past the mask
			end
		end
		return r;
	endfunction

	// ======================================================================
	// bus tasks
	// ======================================================================
	task report_error(input string msg);
		errors++;
		$display("ERROR %0t ns: %s", $time, msg);
	endtask

	task abort_timeout(input string what);
		$display("TIMEOUT at %0t ns: no response on the %s", $time, what);
		$display("Regression failed");
		$finish;
	endtask

	task random_pause();
		int d;
		d = rand_bits(delay_bits);
		repeat (d)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task send_write(input logic [7:0] addr, input logic [31:0] data, input logic [3:0] strb);
		int n;
		awaddr  = addr;
		wdata   = data;
		wstrb   = strb;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		n = 0;
		do
		begin
			@(negedge clk);                      // stable sample point
			n++;
		end
		while (!(awready && wready) && n < TIMEOUT);
		if (!(awready && wready))
			abort_timeout("write address/data channel");
		@(posedge clk);                          // transfer edge
		#1;
		awvalid = 1'b0;
		wvalid  = 1'b0;
	endtask

	task get_bresp(output logic [1:0] resp);
		int n;
		random_pause();
		bready = 1'b1;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
		end
		while (!bvalid && n < TIMEOUT);
		if (!bvalid)
			abort_timeout("write response channel");
		resp = bresp;
		@(posedge clk);
		#1;
		bready = 1'b0;
	endtask

	task send_read(input logic [7:0] addr);
		int n;
		araddr  = addr;
		arvalid = 1'b1;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
		end
		while (!arready && n < TIMEOUT);
		if (!arready)
			abort_timeout("read address channel");
		@(posedge clk);
		#1;
		arvalid = 1'b0;
	endtask

	task get_rdata(output logic [31:0] data, output logic [1:0] resp);
		int n;
		random_pause();
		rready = 1'b1;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
		end
		while (!rvalid && n < TIMEOUT);
		if (!rvalid)
			abort_timeout("read data channel");
		data = rdata;
		resp = rresp;
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	task axi_write(input logic [7:0] addr, input logic [31:0] data, input logic [3:0] strb,
		output logic [1:0] resp);
		send_write(addr, data, strb);
		get_bresp(resp);
	endtask

	task axi_read(input logic [7:0] addr, output logic [31:0] data, output logic [1:0] resp);
		send_read(addr);
		get_rdata(data, resp);
	endtask

	// ======================================================================
	// operations
	// ======================================================================
	// control write with a status read whose address lands one edge later, before done sets
	task start_op(input logic [31:0] ctrl, output logic [1:0] resp, output logic [31:0] status);
		logic [1:0] sresp;
		send_write(ADDR_CTRL, ctrl, 4'hf);
		send_read(ADDR_STATUS);
		get_bresp(resp);
		get_rdata(status, sresp);
	endtask

	task run_op(input logic [127:0] a, input logic [127:0] b, input logic [2:0] op,
		input logic [1:0] w);
		logic [1:0]   resp;
		logic [31:0]  data;
		logic [127:0] got;
		int           n;
		last_exp = model(a, b, op, w);
		for (int k = 0; k < 4; k++)
		begin
			axi_write(8'(ADDR_A0 + 4 * k), a[127-32*k -: 32], 4'hf, resp);  // word 0 on top
			if (resp != RESP_OKAY)
				report_error("operand A write not OKAY");
			axi_write(8'(ADDR_B0 + 4 * k), b[127-32*k -: 32], 4'hf, resp);
			if (resp != RESP_OKAY)
				report_error("operand B write not OKAY");
		end
		start_op({26'd0, w, 1'b0, op}, resp, data);
		if (resp != RESP_OKAY)
			report_error("control write not OKAY");
		if (data[0] !== 1'b0)
			report_error("status done set before the op completed");
		n = 0;
		data = '0;
		while (!data[0] && n < 8)                // poll with its own limit
		begin
			axi_read(ADDR_STATUS, data, resp);
			n++;
		end
		if (!data[0])
			abort_timeout("status done flag");
		if (n != 1)
			report_error("done missing on first status read after the write response");
		got = '0;
		for (int k = 0; k < 4; k++)
		begin
			axi_read(8'(ADDR_RES0 + 4 * k), data, resp);
			got = {got[95:0], data};
			if (resp != RESP_OKAY)
				report_error("result read not OKAY");
		end
		if (got !== last_exp)
			report_error($sformatf("op %0d width %0d got %h expected %h", op, w, got, last_exp));
	endtask

	task check_unmapped_read(input logic [7:0] addr);
		logic [31:0] data;
		logic [1:0]  resp;
		axi_read(addr, data, resp);
		if (resp != RESP_SLVERR || data != 32'd0)
			report_error($sformatf("read of %h gave resp %0d data %h", addr, resp, data));
	endtask

	task end_test(input string name, input int e0);
		tests++;
		if (errors != e0)
			failed++;
		$display("test %s: %s, %0d errors", name, (errors == e0) ? "ok" : "FAILED", errors - e0);
	endtask

	// ======================================================================
	// sequence
	// ======================================================================
	initial
	begin
		int          e0;
		logic [1:0]  resp;
		logic [31:0] data;
		rst     = 1'b1;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		e0 = errors;
		for (int i = 0; i < 60; i++)
			run_op(rand_word(), rand_word(), rand_bits(1) ? OP_SUB : OP_ADD, 2'(i % 3));
		end_test("lane arithmetic", e0);

		e0 = errors;
		for (int i = 0; i < 40; i++)
			run_op(rand_word(), rand_word(), 3'(rand_bits(2)) + 3'd1, 2'(i % 3));  // AND..XOR
		end_test("lane logic", e0);

		e0 = errors;
		for (int i = 0; i < 30; i++)
			run_op(rand_word(), rand_word(), OP_PRM, 2'(rand_bits(2)));
		end_test("permute", e0);

		e0 = errors;
		for (int i = 0; i < 4; i++)
		begin
			run_op(rand_word(), rand_word(), 3'd7, 2'(rand_bits(2)));
			run_op(rand_word(), rand_word(), 3'(rand_bits(3) % 6), 2'd3);  // lane op, width 3
		end
		end_test("reserved encodings", e0);

		e0 = errors;
		delay_bits = 3;                            // up to 7 idle cycles before ready
		for (int i = 0; i < 20; i++)
			run_op(rand_word(), rand_word(), 3'(rand_bits(3)), 2'(rand_bits(2)));
		delay_bits = 1;
		end_test("back-pressure", e0);

		e0 = errors;
		axi_write(8'h40, rand_bits(32), 4'hf, resp);
		if (resp != RESP_SLVERR)
			report_error("unmapped write not SLVERR");
		check_unmapped_read(8'h28);
		check_unmapped_read(8'h02);                // misaligned inside operand A
		check_unmapped_read(8'hc0);
		axi_write(ADDR_STATUS, 32'h1, 4'hf, resp);
		if (resp != RESP_OKAY)
			report_error("status write not OKAY");
		axi_write(8'(ADDR_RES0 + 4), rand_bits(32), 4'hf, resp);
		if (resp != RESP_OKAY)
			report_error("result write not OKAY");
		for (int k = 0; k < 4; k++)
		begin
			axi_read(8'(ADDR_RES0 + 4 * k), data, resp);
			if (data != last_exp[127-32*k -: 32])
				report_error($sformatf("result word %0d changed to %h", k, data));
		end
		end_test("address errors", e0);

		$display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== vlog.f ====
logic/wideword_pkg.sv
logic/alu_req_if.sv
logic/lane_alu.sv
logic/byte_permute.sv
logic/alu_core.sv
logic/axil_regs.sv
logic/wideword_alu_top.sv
verif/wideword_assertions.sv
verif/tb_wideword_alu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator from vlog.f, runs it and checks sim.log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_wideword_alu -f vlog.f \
	-o sim_tb > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

# an aborted run, such as a failed assertion, is logged as a failure
./obj_dir/sim_tb > sim.log 2>&1 || echo "Regression failed" >> sim.log

cat sim.log
grep -q "Regression failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
